// ==== cpuPkg.sv ====
/* Widths, opcodes and the two instruction formats of the core
   Pipeline register contents, writeback report and branch redirect */
package cpuPkg;

    //--------------------------------------------------------------------------
    // Widths
    //--------------------------------------------------------------------------

    // Word address into the instruction memory
    localparam int addrWidth = 16;
    // Register, operand and instruction width
    localparam int dataWidth = 32;
    // Architectural registers, r0 reads as zero
    localparam int regCount  = 32;

    //--------------------------------------------------------------------------
    // Instruction set
    //--------------------------------------------------------------------------

    // Any other value retires as a no-op
    typedef enum logic [5:0] {
        opAdd  = 6'h01,
        opSub  = 6'h02,
        opAnd  = 6'h03,
        opOr   = 6'h04,
        opAddi = 6'h08,
        opBeq  = 6'h10
    } opcodeE;

    // Register format, rd = rs1 op rs2
    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [10:0] unused;
    } rTypeS;

    // Immediate format, ADDI and BEQ
    // BEQ compares rd with rs1 and jumps to imm as a word address
    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [15:0] imm;
    } iTypeS;

    // Same word seen in either format, opcode and rd line up
    typedef union packed {
        rTypeS r;
        iTypeS i;
    } instrU;

    //--------------------------------------------------------------------------
    // Pipeline registers
    //--------------------------------------------------------------------------

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] pc;
        instrU                instr;
    } ifIdS;

    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] pc;
        opcodeE               opcode;
        logic [4:0]           rd;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        // Sign-extended immediate
        logic [dataWidth-1:0] imm;
    } idExS;

    // Register write, also the retire report
    typedef struct packed {
        logic                 valid;
        logic [4:0]           idx;
        logic [dataWidth-1:0] data;
    } wbS;

    // Redirect from execute
    typedef struct packed {
        logic                 taken;
        logic [addrWidth-1:0] target;
    } branchS;

endpackage

// ==== instrFetch.sv ====
/* Fetch stage: program counter, stall hold, branch redirect
   and the fetch-to-decode pipeline register */
`timescale 1ns/1ps

module instrFetch (
    input  logic                         Clock,
    input  logic                         arstN,
    input  logic                         nStall,
    input  cpuPkg::branchS               branch,
    input  logic [cpuPkg::dataWidth-1:0] InstrMem,
    output logic [cpuPkg::addrWidth-1:0] InstrAddr,
    output cpuPkg::ifIdS                 ifId
);

    import cpuPkg::*;

    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] pcNext;
    logic                 fetchOk;

    //--------------------------------------------------------------------------
    // Next PC
    //--------------------------------------------------------------------------

    // Redirect wins over stall
    always_comb begin
        if (branch.taken) begin
            pcNext = branch.target;
        end else if (nStall) begin
            pcNext = pc + 1'b1;
        end else begin
            pcNext = pc;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Address bus reads zero while stalled
    assign InstrAddr = pc & {addrWidth{nStall}};

    //--------------------------------------------------------------------------
    // Fetch-to-decode register
    //--------------------------------------------------------------------------

    // Bubble on stall, squash the word behind a taken branch
    assign fetchOk = nStall & ~branch.taken;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
        end else begin
            ifId.valid <= fetchOk;
            ifId.pc    <= pc;
            ifId.instr <= InstrMem;
        end
    end

endmodule

// ==== instrDecode.sv ====
/* Decode stage: field extraction, register file reads
   and the decode-to-execute pipeline register */
`timescale 1ns/1ps

module instrDecode (
    input  logic                         Clock,
    input  logic                         arstN,
    input  cpuPkg::ifIdS                 ifId,
    input  cpuPkg::branchS               branch,
    output logic [4:0]                   rdIdxA,
    output logic [4:0]                   rdIdxB,
    input  logic [cpuPkg::dataWidth-1:0] rdDataA,
    input  logic [cpuPkg::dataWidth-1:0] rdDataB,
    output cpuPkg::idExS                 idEx
);

    import cpuPkg::*;

    instrU                instr;
    opcodeE               opcode;
    logic [dataWidth-1:0] immExt;

    //--------------------------------------------------------------------------
    // Field extraction
    //--------------------------------------------------------------------------

    assign instr  = ifId.instr;
    // Opcode sits in the same bits in both formats
    assign opcode = instr.r.opcode;

    // Immediate view, sign-extended to full width
    assign immExt = {{(dataWidth-16){instr.i.imm[15]}}, instr.i.imm};

    // Port A always reads rs1
    assign rdIdxA = instr.r.rs1;

    // BEQ compares rd against rs1, everything else wants rs2 on port B
    // For ADDI the B read is don't-care
    always_comb begin
        if (opcode == opBeq) begin
            rdIdxB = instr.i.rd;
        end else begin
            rdIdxB = instr.r.rs2;
        end
    end

    //--------------------------------------------------------------------------
    // Decode-to-execute register
    //--------------------------------------------------------------------------

    // Values come from regFile with the execute write already bypassed in
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else begin
            // Taken branch in execute kills the instruction now in decode
            idEx.valid  <= ifId.valid & ~branch.taken;
            idEx.pc     <= ifId.pc;
            idEx.opcode <= opcode;
            idEx.rd     <= instr.r.rd;
            idEx.opA    <= rdDataA;
            idEx.opB    <= rdDataB;
            idEx.imm    <= immExt;
        end
    end

endmodule

// ==== regFile.sv ====
/* 32 x 32 register file with two read ports and one write port
   and a write-through bypass from the execute stage */
`timescale 1ns/1ps

module regFile (
    input  logic                         Clock,
    input  logic                         arstN,
    input  cpuPkg::wbS                   wb,
    input  logic [4:0]                   rdIdxA,
    input  logic [4:0]                   rdIdxB,
    output logic [cpuPkg::dataWidth-1:0] rdDataA,
    output logic [cpuPkg::dataWidth-1:0] rdDataB
);

    import cpuPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // r0 never written
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.idx != 5'd0)) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // r0 reads zero and a same-cycle write is forwarded over the stored value
    function automatic logic [dataWidth-1:0] readPort(input logic [4:0] idx);
        logic [dataWidth-1:0] value;
        if (idx == 5'd0) begin
            value = '0;
        end else if (wb.valid && (wb.idx == idx)) begin
            value = wb.data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    // Re-evaluated on index, write port and stored value changes
    always_comb begin
        rdDataA = readPort(rdIdxA);
        rdDataB = readPort(rdIdxB);
    end

endmodule

// ==== execute.sv ====
/* Execute stage: ALU, branch resolution and flush request,
   register write and the registered writeback report */
`timescale 1ns/1ps

module execute (
    input  logic           Clock,
    input  logic           arstN,
    input  cpuPkg::idExS   idEx,
    output cpuPkg::wbS     wb,
    output cpuPkg::branchS branch,
    output cpuPkg::wbS     Writeback
);

    import cpuPkg::*;

    logic [dataWidth-1:0] result;
    logic                 writesReg;
    logic                 operandsEqual;

    //--------------------------------------------------------------------------
    // ALU
    //--------------------------------------------------------------------------

    always_comb begin
        case (idEx.opcode)
            opAdd:   result = idEx.opA + idEx.opB;
            opSub:   result = idEx.opA - idEx.opB;
            opAnd:   result = idEx.opA & idEx.opB;
            opOr:    result = idEx.opA | idEx.opB;
            opAddi:  result = idEx.opA + idEx.imm;
            // BEQ and unknown opcodes produce nothing
            default: result = '0;
        endcase
    end

    // Only the five arithmetic ops write, and never r0
    assign writesReg = idEx.valid
                     && (idEx.opcode inside {opAdd, opSub, opAnd, opOr, opAddi})
                     && (idEx.rd != 5'd0);

    // Straight into the regFile write port and its bypass
    assign wb.valid = writesReg;
    assign wb.idx   = idEx.rd;
    assign wb.data  = result;

    //--------------------------------------------------------------------------
    // Branch resolution
    //--------------------------------------------------------------------------

    assign operandsEqual = (idEx.opA == idEx.opB);

    // Absolute word target from the low immediate bits
    // Taken flushes decode and fetch at the next edge
    assign branch.taken  = idEx.valid && (idEx.opcode == opBeq) && operandsEqual;
    assign branch.target = idEx.imm[addrWidth-1:0];

    //--------------------------------------------------------------------------
    // Writeback report
    //--------------------------------------------------------------------------

    // One cycle behind the register write
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            Writeback <= '0;
        end else begin
            Writeback <= wb;
        end
    end

endmodule

// ==== cpuCore.sv ====
/* Top level of the three-stage core
   Fetch, decode, register file and execute on one memory port */
`timescale 1ns/1ps

module cpuCore (
    input  logic                         Clock,
    input  logic                         arstN,
    input  logic                         nStall,
    input  logic [cpuPkg::dataWidth-1:0] InstrMem,
    output logic [cpuPkg::addrWidth-1:0] InstrAddr,
    output cpuPkg::wbS                   Writeback
);

    import cpuPkg::*;

    // Stage-to-stage registers
    ifIdS   ifId;
    idExS   idEx;
    // Execute results fed back
    wbS     wb;
    branchS branch;
    // Register file read ports
    logic [4:0]           rdIdxA;
    logic [4:0]           rdIdxB;
    logic [dataWidth-1:0] rdDataA;
    logic [dataWidth-1:0] rdDataB;

    //--------------------------------------------------------------------------
    // Stages
    //--------------------------------------------------------------------------

    instrFetch uFetch (
        .Clock(Clock), .arstN(arstN), .nStall(nStall), .branch(branch),
        .InstrMem(InstrMem), .InstrAddr(InstrAddr), .ifId(ifId)
    );

    instrDecode uDecode (
        .Clock(Clock), .arstN(arstN), .ifId(ifId), .branch(branch),
        .rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .idEx(idEx)
    );

    // Written from execute, read from decode
    regFile uRegFile (
        .Clock(Clock), .arstN(arstN), .wb(wb),
        .rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    execute uExecute (
        .Clock(Clock), .arstN(arstN), .idEx(idEx),
        .wb(wb), .branch(branch), .Writeback(Writeback)
    );

endmodule

// ==== tbClock.sv ====
/* Testbench clock, 100 ns period, and active-low reset
   held for 5 cycles at start and again on each request */
`timescale 1ns/1ps

module tbClock (
    input  logic resetReq,
    output logic Clock,
    output logic arstN
);

    localparam int halfPeriod  = 50;
    localparam int resetCycles = 5;

    initial begin
        Clock = 1'b0;
        forever #halfPeriod Clock = ~Clock;
    end

    // Release just after an edge, re-assert when asked
    initial begin
        arstN = 1'b0;
        forever begin
            repeat (resetCycles) @(posedge Clock);
            #1 arstN = 1'b1;
            @(posedge resetReq);
            arstN = 1'b0;
        end
    end

endmodule

// ==== cpuCoreTb.sv ====
/* Testbench of the core with its program table and memory model,
   ISA reference model, nStall stimulus and in-order writeback checks */
`timescale 1ns/1ps

module cpuCoreTb;

    import cpuPkg::*;

    localparam int progLen      = 19;
    localparam int timeoutLimit = 100;
    localparam int drainCycles  = 20;
    localparam int maxSteps     = 500;
    localparam int runCount     = 2;

    // Per run settings of nStall, reset request and expected report count
    typedef struct packed {
        logic       stallRandom;
        logic       needReset;
        logic [7:0] expReports;
    } runS;

    // Same program twice and the second time with random stalls
    localparam runS runTable [runCount] = '{
        '{1'b0, 1'b0, 8'd11},
        '{1'b1, 1'b1, 8'd11}
    };

    logic                 Clock;
    logic                 arstN;
    logic                 resetReq;
    logic                 nStall;
    logic                 stallRandom;
    logic [dataWidth-1:0] InstrMem;
    logic [addrWidth-1:0] InstrAddr;
    wbS                   Writeback;

    logic [dataWidth-1:0] progMem [32];
    wbS                   expected [$];
    int                   checks;
    int                   errors;

    tbClock clockGen (.resetReq(resetReq), .Clock(Clock), .arstN(arstN));

    cpuCore DUT (
        .Clock(Clock), .arstN(arstN), .nStall(nStall), .InstrMem(InstrMem),
        .InstrAddr(InstrAddr), .Writeback(Writeback)
    );

    //--------------------------------------------------------------------------
    // Program and memory model
    //--------------------------------------------------------------------------

    function automatic logic [31:0] rWord(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {op, rd, rs1, rs2, 11'd0};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic void loadProgram();
        progMem[0]  = iWord(opAddi, 5'd1, 5'd0, 16'd5);
        progMem[1]  = iWord(opAddi, 5'd2, 5'd0, 16'hFFFD);   // -3
        // Dependent chain through the bypass
        progMem[2]  = rWord(opAdd, 5'd3, 5'd1, 5'd2);
        progMem[3]  = rWord(opSub, 5'd4, 5'd3, 5'd1);
        progMem[4]  = rWord(opAnd, 5'd5, 5'd4, 5'd1);
        progMem[5]  = rWord(opOr, 5'd6, 5'd5, 5'd2);
        // Write to r0 is dropped and r0 still reads zero
        progMem[6]  = iWord(opAddi, 5'd0, 5'd1, 16'd7);
        progMem[7]  = rWord(opAdd, 5'd7, 5'd0, 5'd1);
        progMem[8]  = rWord(6'h3F, 5'd9, 5'd1, 5'd2);
        progMem[9]  = iWord(opAddi, 5'd8, 5'd7, 16'hFFFF);   // -1
        // Taken branch skips 11 and 12
        progMem[10] = iWord(opBeq, 5'd1, 5'd7, 16'd13);
        progMem[11] = iWord(opAddi, 5'd9, 5'd0, 16'd99);
        progMem[12] = iWord(opAddi, 5'd10, 5'd0, 16'd77);
        // Not taken
        progMem[13] = iWord(opBeq, 5'd2, 5'd1, 16'd11);
        progMem[14] = iWord(opAddi, 5'd11, 5'd0, 16'd1);
        progMem[15] = rWord(opSub, 5'd12, 5'd11, 5'd8);
        progMem[16] = rWord(6'h00, 5'd3, 5'd1, 5'd1);
        progMem[17] = rWord(opOr, 5'd13, 5'd12, 5'd0);
        // End loop on itself
        progMem[18] = iWord(opBeq, 5'd0, 5'd0, 16'd18);
    endfunction

    // Past the program end the word is an unknown opcode carrying its address
    function automatic logic [31:0] memWord(input logic [addrWidth-1:0] addr);
        logic [31:0] word;
        if (addr < addrWidth'(progLen)) begin
            word = progMem[addr[4:0]];
        end else begin
            word = {6'h3F, 10'd0, addr};
        end
        return word;
    endfunction

    always_comb InstrMem = memWord(InstrAddr);

    // nStall moves just after each rising edge and is high about three cycles in four
    always @(posedge Clock) begin
        #1;
        if (stallRandom) begin
            nStall = (($urandom % 4) != 0);
        end else begin
            nStall = 1'b1;
        end
    end

    //--------------------------------------------------------------------------
    // Reference model and checks
    //--------------------------------------------------------------------------

    // Walks the program in order and returns 1 once the end loop is reached
    function automatic bit buildModel();
        logic [dataWidth-1:0] regs [regCount];
        logic [31:0]          word;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] imm;
        logic [dataWidth-1:0] res;
        logic [5:0]           op;
        logic [4:0]           rd;
        logic [addrWidth-1:0] pc;
        logic                 writes;
        bit                   halted;
        int                   steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        expected.delete();
        pc = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < maxSteps) begin
            word = memWord(pc);
            op = word[31:26];
            rd = word[25:21];
            a = regs[word[20:16]];
            b = regs[word[15:11]];
            imm = {{16{word[15]}}, word[15:0]};
            writes = 1'b1;
            res = '0;
            case (op)
                opAdd:   res = a + b;
                opSub:   res = a - b;
                opAnd:   res = a & b;
                opOr:    res = a | b;
                opAddi:  res = a + imm;
                default: writes = 1'b0;
            endcase
            if (writes && rd != 5'd0) begin
                regs[rd] = res;
                expected.push_back('{valid: 1'b1, idx: rd, data: res});
            end
            // BEQ compares rd with rs1 and jumps to the absolute word address
            if (op == opBeq && regs[rd] == a) begin
                halted = (word[15:0] == pc);
                pc = word[15:0];
            end else begin
                pc = pc + 16'd1;
            end
            steps++;
        end
        return halted;
    endfunction

    function automatic void checkValue(input string name, input logic [31:0] expVal,
                                       input logic [31:0] actVal);
        checks++;
        assert (actVal === expVal) else begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
        end
    endfunction

    function automatic void noteProblem(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endfunction

    task automatic waitReset(input logic level);
        int events;
        events = 0;
        while (arstN !== level && events < timeoutLimit) begin
            @(arstN or posedge Clock);
            events++;
        end
        if (arstN !== level) begin
            noteProblem($sformatf("reset never went to %0b", level));
        end
    endtask

    task automatic runProgram(input int runIdx);
        runS cfg;
        int  got;
        int  idle;
        int  errorsBefore;
        cfg = runTable[runIdx];
        errorsBefore = errors;
        got = 0;
        idle = 0;
        if (cfg.needReset) begin
            stallRandom = 1'b0;
            resetReq = 1'b1;
            waitReset(1'b0);
            resetReq = 1'b0;
        end
        waitReset(1'b1);
        // Out of reset and before the first fetch edge
        checkValue("InstrAddr", '0, 32'(InstrAddr));
        checkValue("Writeback.valid", '0, 32'(Writeback.valid));
        stallRandom = cfg.stallRandom;
        // Reports are stable at the falling edge
        while (got < expected.size() && idle < timeoutLimit) begin
            @(negedge Clock);
            // Memory address reads zero while fetch is stalled
            if (!nStall) begin
                checkValue("InstrAddr", '0, 32'(InstrAddr));
            end
            if (Writeback.valid) begin
                checkValue("Writeback.idx", 32'(expected[got].idx), 32'(Writeback.idx));
                checkValue("Writeback.data", expected[got].data, Writeback.data);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < expected.size()) begin
            noteProblem($sformatf("no report for %0d cycles, %0d of %0d seen",
                                  timeoutLimit, got, expected.size()));
        end
        // End loop and squashed words must stay silent
        for (int i = 0; i < drainCycles; i++) begin
            @(negedge Clock);
            assert (!Writeback.valid) else begin
                noteProblem($sformatf("unexpected report for r%0d", Writeback.idx));
            end
        end
        checkValue("report count", 32'(cfg.expReports), got);
        $display("Run %0d, nStall %s: %0d reports checked, %0d errors", runIdx,
                 cfg.stallRandom ? "random" : "high", got, errors - errorsBefore);
    endtask

    initial begin
        void'($urandom(32'h623e));
        resetReq = 1'b0;
        stallRandom = 1'b0;
        nStall = 1'b1;
        checks = 0;
        errors = 0;
        loadProgram();
        if (!buildModel()) begin
            noteProblem("reference model never reached the end loop");
        end
        for (int i = 0; i < runCount; i++) begin
            runProgram(i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
cpuPkg.sv
instrFetch.sv
instrDecode.sv
regFile.sv
execute.sv
cpuCore.sv
tbClock.sv
cpuCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= cpuCoreTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAILMSG   ?= Test failed
VFLAGS    ?= --binary --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
